// File: video_macros.svh
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// stored line geometry, in source pixels
`define LINE_PIXELS     400
// pixel enables between source hsync fall and the first stored pixel
`define CAPTURE_OFFSET  40

// 800x600 raster, horizontal counts in vga enables
`define H_TOTAL         1040
`define H_ACTIVE        800
`define H_FRONT         56
`define H_SYNC          120

// vertical counts in lines
`define V_TOTAL         666
`define V_ACTIVE        600
`define V_FRONT         37
`define V_SYNC          6

// clocks per pixel enable, normal and single-step
`define PIXEL_DIV       6
`define SLOW_DIV        1280

`endif

// File: videoPkg.sv
`default_nettype none
`include "video_macros.svh"

package videoPkg;

	// bit 0 red, bit 1 green, bit 2 blue
	typedef logic [2:0] rgbPixel;

	// pixel index inside one stored line
	typedef logic [$clog2(`LINE_PIXELS)-1:0] lineAddr;

	// ping-pong bank number
	typedef logic bankSel;

	// horizontal raster phases, waitFrame only after reset
	typedef enum logic [2:0] {
		waitFrame,
		backPorch,
		active,
		frontPorch,
		syncPulse
	} scanState;

endpackage

`default_nettype wire

// File: lineSwapIf.sv
`timescale 1ns/1ps
`default_nettype none

// line hand-over from capture to replay, four-phase req/ack
interface lineSwapIf;
	import videoPkg::*;

	logic   req;
	logic   ack;
	// one clock when replay leaves its previous bank
	logic   done;
	// bank just filled, stable while req is high
	bankSel bank;

	modport capture (output req, output bank, input ack, input done);
	modport replay (input req, input bank, output ack, output done);
endinterface

`default_nettype wire

// File: clockEnables.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_macros.svh"

module clockEnables (
	input  wire logic CLK100MHZ,
	input  wire logic reset,
	input  wire logic delayDebug,
	output logic      pixelEn,
	output logic      vgaEn
);
	localparam int PIX_W  = $clog2(`PIXEL_DIV);
	localparam int SLOW_W = $clog2(`SLOW_DIV);

	logic [PIX_W-1:0]  pixCount;
	logic [SLOW_W-1:0] slowCount;
	logic              vgaCount;
	logic              pixWrap;
	logic              slowWrap;

	assign pixWrap  = pixCount == PIX_W'(`PIXEL_DIV - 1);
	assign slowWrap = slowCount == SLOW_W'(`SLOW_DIV - 1);

	// free-running dividers, all restart at zero after reset
	always_ff @(posedge CLK100MHZ) begin
		if (reset) begin
			pixCount  <= '0;
			slowCount <= '0;
			vgaCount  <= 1'b0;
		end else begin
			pixCount  <= pixWrap ? '0 : pixCount + 1'b1;
			slowCount <= slowWrap ? '0 : slowCount + 1'b1;
			vgaCount  <= ~vgaCount;
		end
	end

	// registered enables, so the first pulse lands on the first clock out of reset
	always_ff @(posedge CLK100MHZ) begin
		if (reset) begin
			pixelEn <= 1'b0;
			vgaEn   <= 1'b0;
		end else begin
			// single-step mode for the debugger
			if (delayDebug)
				pixelEn <= slowCount == '0;
			else
				pixelEn <= pixCount == '0;
			vgaEn <= vgaCount == 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: lineCapture.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_macros.svh"

module lineCapture (
	input  wire logic              CLK100MHZ,
	input  wire logic              reset,
	input  wire logic              pixelEn,
	input  wire videoPkg::rgbPixel srcRgb,
	input  wire logic              srcHsync,
	input  wire logic              srcVsync,
	output logic                   writeEn,
	output videoPkg::lineAddr      writeAddr,
	output videoPkg::bankSel       writeBank,
	output videoPkg::rgbPixel      writePixel,
	lineSwapIf.capture             swap
);
	import videoPkg::*;

	typedef enum logic [1:0] {capIdle, capOffset, capWrite} captureState;

	localparam int      OFFSET_W    = $clog2(`CAPTURE_OFFSET);
	localparam lineAddr LAST_ADDR   = lineAddr'(`LINE_PIXELS - 1);
	localparam lineAddr PENULT_ADDR = lineAddr'(`LINE_PIXELS - 2);

	captureState         state;
	logic [OFFSET_W-1:0] offsetCount;
	logic                hsyncPrev;
	logic                hsyncFall;

	assign hsyncFall = hsyncPrev && !srcHsync;

	// sampled on every pixel enable and written one clock later
	always_ff @(posedge CLK100MHZ) begin
		hsyncPrev <= srcHsync;
		if (pixelEn)
			writePixel <= srcRgb;
	end

	always_ff @(posedge CLK100MHZ) begin
		if (reset) begin
			state       <= capIdle;
			offsetCount <= '0;
			writeEn     <= 1'b0;
			writeAddr   <= '0;
			writeBank   <= 1'b1;
			swap.req    <= 1'b0;
			swap.bank   <= 1'b0;
		end else begin
			writeEn <= 1'b0;
			case (state)
				capIdle: begin
					// a line arriving while the last one is still pending is dropped
					if (hsyncFall && !srcVsync && !swap.req) begin
						state       <= capOffset;
						offsetCount <= '0;
					end
				end
				capOffset: begin
					if (pixelEn) begin
						if (offsetCount == OFFSET_W'(`CAPTURE_OFFSET - 1)) begin
							state     <= capWrite;
							writeEn   <= 1'b1;
							writeAddr <= '0;
						end else begin
							offsetCount <= offsetCount + 1'b1;
						end
					end
				end
				capWrite: begin
					if (pixelEn) begin
						writeEn   <= 1'b1;
						writeAddr <= writeAddr + 1'b1;
						if (writeAddr == PENULT_ADDR)
							state <= capIdle;
					end
				end
				default: state <= capIdle;
			endcase

			// offer the full line to replay
			if (writeEn && writeAddr == LAST_ADDR) begin
				swap.req  <= 1'b1;
				swap.bank <= writeBank;
			end else if (swap.ack) begin
				swap.req <= 1'b0;
			end

			// once replay takes the offered bank the other one is free
			if (swap.done)
				writeBank <= ~swap.bank;
		end
	end

endmodule

`default_nettype wire

// File: lineBuffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_macros.svh"

module lineBuffer (
	input  wire logic              CLK100MHZ,
	input  wire logic              writeEn,
	input  wire videoPkg::lineAddr writeAddr,
	input  wire videoPkg::bankSel  writeBank,
	input  wire videoPkg::rgbPixel writePixel,
	input  wire videoPkg::lineAddr readAddr,
	input  wire videoPkg::bankSel  readBank,
	output videoPkg::rgbPixel      readPixel
);
	import videoPkg::*;

	// two lines, one being filled and one being shown
	rgbPixel lineRam [2][`LINE_PIXELS];

	always_ff @(posedge CLK100MHZ) begin
		if (writeEn)
			lineRam[writeBank][writeAddr] <= writePixel;
	end

	// read latency of one clock is matched by the sync delay downstream
	always_ff @(posedge CLK100MHZ) begin
		readPixel <= lineRam[readBank][readAddr];
	end

	writeBankFree: assert property (@(posedge CLK100MHZ)
		writeEn |-> writeBank != readBank)
		else $error("capture wrote into the bank under replay");

endmodule

`default_nettype wire

// File: scanTiming.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_macros.svh"

module scanTiming (
	input  wire logic         CLK100MHZ,
	input  wire logic         reset,
	input  wire logic         vgaEn,
	lineSwapIf.replay         swap,
	output videoPkg::lineAddr readAddr,
	output videoPkg::bankSel  readBank,
	output logic              hsync,
	output logic              vsync,
	output logic              activeVideo,
	output logic              outOfScreen,
	output logic              vgaNewline
);
	import videoPkg::*;

	localparam int H_W         = $clog2(`H_TOTAL);
	localparam int V_W         = $clog2(`V_TOTAL);
	localparam int SYNC_START  = `H_ACTIVE + `H_FRONT;
	localparam int BACK_START  = SYNC_START + `H_SYNC;
	localparam int VSYNC_START = `V_ACTIVE + `V_FRONT;
	localparam int VSYNC_END   = VSYNC_START + `V_SYNC;

	scanState       state;
	logic [H_W-1:0] hCount;
	logic [V_W-1:0] vCount;
	logic [V_W-1:0] vNext;
	logic           lineEnd;

	assign lineEnd = state == backPorch && hCount == H_W'(`H_TOTAL - 1);
	assign vNext   = (vCount == V_W'(`V_TOTAL - 1)) ? '0 : vCount + 1'b1;

	// each line runs active, front porch, sync and then back porch
	always_ff @(posedge CLK100MHZ) begin
		if (reset) begin
			state  <= waitFrame;
			hCount <= '0;
			vCount <= '0;
		end else if (vgaEn) begin
			hCount <= hCount + 1'b1;
			case (state)
				waitFrame: begin
					// start in the back porch of the last line of a frame
					state  <= backPorch;
					hCount <= H_W'(BACK_START);
					vCount <= V_W'(`V_TOTAL - 1);
				end
				active: begin
					if (hCount == H_W'(`H_ACTIVE - 1))
						state <= frontPorch;
				end
				frontPorch: begin
					if (hCount == H_W'(SYNC_START - 1))
						state <= syncPulse;
				end
				syncPulse: begin
					if (hCount == H_W'(BACK_START - 1))
						state <= backPorch;
				end
				backPorch: begin
					if (lineEnd) begin
						state  <= active;
						hCount <= '0;
						vCount <= vNext;
					end
				end
				default: state <= waitFrame;
			endcase
		end
	end

	// new bank is only taken at a line start, so a line never mixes banks
	always_ff @(posedge CLK100MHZ) begin
		if (reset) begin
			swap.ack  <= 1'b0;
			swap.done <= 1'b0;
			readBank  <= 1'b0;
		end else begin
			swap.done <= 1'b0;
			if (vgaEn && lineEnd && swap.req && !swap.ack) begin
				swap.ack  <= 1'b1;
				swap.done <= 1'b1;
				readBank  <= swap.bank;
			end else if (swap.ack && !swap.req) begin
				swap.ack <= 1'b0;
			end
		end
	end

	// each stored pixel spans two vga pixels
	assign readAddr    = (state == active) ? lineAddr'(hCount >> 1) : '0;
	assign activeVideo = state == active && vCount < V_W'(`V_ACTIVE);
	assign outOfScreen = state != waitFrame && !activeVideo;
	assign hsync       = state == syncPulse;
	assign vsync       = vCount >= V_W'(VSYNC_START) && vCount < V_W'(VSYNC_END);
	assign vgaNewline  = vgaEn && lineEnd && vNext < V_W'(`V_ACTIVE);

	ackNeedsReq: assert property (@(posedge CLK100MHZ) disable iff (reset)
		$rose(swap.ack) |-> swap.req)
		else $error("ack raised with no pending req");

	reqDropsAfterAck: assert property (@(posedge CLK100MHZ) disable iff (reset)
		$fell(swap.req) |-> swap.ack)
		else $error("req dropped before ack");

	ackDropsAfterReq: assert property (@(posedge CLK100MHZ) disable iff (reset)
		$fell(swap.ack) |-> !swap.req)
		else $error("ack dropped while req still high");

endmodule

`default_nettype wire

// File: overlayMixer.sv
`timescale 1ns/1ps
`default_nettype none

module overlayMixer (
	input  wire logic              CLK100MHZ,
	input  wire logic              reset,
	input  wire logic              hsync,
	input  wire logic              vsync,
	input  wire logic              activeVideo,
	input  wire logic              outOfScreen,
	input  wire videoPkg::rgbPixel readPixel,
	input  wire videoPkg::rgbPixel debugRgb,
	output logic [3:0]             vgaR,
	output logic [3:0]             vgaG,
	output logic [3:0]             vgaB,
	output logic                   vgaHs,
	output logic                   vgaVs
);
	import videoPkg::*;

	logic    activeDelayed;
	logic    outDelayed;
	rgbPixel basePixel;
	rgbPixel mixedPixel;

	// line the flags up with the line RAM output
	always_ff @(posedge CLK100MHZ) begin
		if (reset) begin
			vgaHs         <= 1'b0;
			vgaVs         <= 1'b0;
			activeDelayed <= 1'b0;
			outDelayed    <= 1'b0;
		end else begin
			vgaHs         <= hsync;
			vgaVs         <= vsync;
			activeDelayed <= activeVideo;
			outDelayed    <= outOfScreen;
		end
	end

	assign basePixel = activeDelayed ? readPixel : '0;
	// debugger paints over the blanked border, never over sync
	assign mixedPixel = (outDelayed && !vgaHs && !vgaVs) ? basePixel ^ debugRgb : basePixel;

	assign vgaR = {4{mixedPixel[0]}};
	assign vgaG = {4{mixedPixel[1]}};
	assign vgaB = {4{mixedPixel[2]}};

endmodule

`default_nettype wire

// File: videoTop.sv
`timescale 1ns/1ps
`default_nettype none

module videoTop (
	input  wire logic              CLK100MHZ,
	input  wire logic              reset,
	input  wire logic              delayDebug,
	input  wire videoPkg::rgbPixel srcRgb,
	input  wire logic              srcHsync,
	input  wire logic              srcVsync,
	input  wire videoPkg::rgbPixel debugRgb,
	output logic                   pixelEn,
	output logic [3:0]             vgaR,
	output logic [3:0]             vgaG,
	output logic [3:0]             vgaB,
	output logic                   vgaHs,
	output logic                   vgaVs,
	output logic                   vgaNewline,
	output logic                   outOfScreen
);
	import videoPkg::*;

	logic    vgaEn;
	logic    writeEn;
	lineAddr writeAddr;
	bankSel  writeBank;
	rgbPixel writePixel;
	lineAddr readAddr;
	bankSel  readBank;
	rgbPixel readPixel;
	logic    hsync;
	logic    vsync;
	logic    activeVideo;

	lineSwapIf swapBus ();

	clockEnables clockEnables_i (
		.CLK100MHZ  (CLK100MHZ),
		.reset      (reset),
		.delayDebug (delayDebug),
		.pixelEn    (pixelEn),
		.vgaEn      (vgaEn)
	);

	lineCapture lineCapture_i (
		.CLK100MHZ  (CLK100MHZ),
		.reset      (reset),
		.pixelEn    (pixelEn),
		.srcRgb     (srcRgb),
		.srcHsync   (srcHsync),
		.srcVsync   (srcVsync),
		.writeEn    (writeEn),
		.writeAddr  (writeAddr),
		.writeBank  (writeBank),
		.writePixel (writePixel),
		.swap       (swapBus.capture)
	);

	lineBuffer lineBuffer_i (
		.CLK100MHZ  (CLK100MHZ),
		.writeEn    (writeEn),
		.writeAddr  (writeAddr),
		.writeBank  (writeBank),
		.writePixel (writePixel),
		.readAddr   (readAddr),
		.readBank   (readBank),
		.readPixel  (readPixel)
	);

	scanTiming scanTiming_i (
		.CLK100MHZ   (CLK100MHZ),
		.reset       (reset),
		.vgaEn       (vgaEn),
		.swap        (swapBus.replay),
		.readAddr    (readAddr),
		.readBank    (readBank),
		.hsync       (hsync),
		.vsync       (vsync),
		.activeVideo (activeVideo),
		.outOfScreen (outOfScreen),
		.vgaNewline  (vgaNewline)
	);

	overlayMixer overlayMixer_i (
		.CLK100MHZ   (CLK100MHZ),
		.reset       (reset),
		.hsync       (hsync),
		.vsync       (vsync),
		.activeVideo (activeVideo),
		.outOfScreen (outOfScreen),
		.readPixel   (readPixel),
		.debugRgb    (debugRgb),
		.vgaR        (vgaR),
		.vgaG        (vgaG),
		.vgaB        (vgaB),
		.vgaHs       (vgaHs),
		.vgaVs       (vgaVs)
	);

endmodule

`default_nettype wire

// File: videoTop_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_macros.svh"

module videoTop_tb;
	import videoPkg::*;

	localparam int LINE_CLOCKS  = `H_TOTAL * 2;
	localparam int FRAME_CLOCKS = `H_TOTAL * `V_TOTAL * 2;

	logic       CLK100MHZ = 1'b0;
	logic       reset;
	logic       delayDebug;
	rgbPixel    srcRgb;
	logic       srcHsync;
	logic       srcVsync;
	rgbPixel    debugRgb;
	logic       pixelEn;
	logic [3:0] vgaR;
	logic [3:0] vgaG;
	logic [3:0] vgaB;
	logic       vgaHs;
	logic       vgaVs;
	logic       vgaNewline;
	logic       outOfScreen;

	// word 0 debug colour, words 1 to LINE_PIXELS one source line
	rgbPixel    vectors [0:`LINE_PIXELS];
	logic [8:0] vecIdx;
	int         checks = 0;
	int         errors = 0;
	int         testStart;
	int         borderChecks;
	logic       prevOut;

	videoTop dut_i (
		.CLK100MHZ   (CLK100MHZ),
		.reset       (reset),
		.delayDebug  (delayDebug),
		.srcRgb      (srcRgb),
		.srcHsync    (srcHsync),
		.srcVsync    (srcVsync),
		.debugRgb    (debugRgb),
		.pixelEn     (pixelEn),
		.vgaR        (vgaR),
		.vgaG        (vgaG),
		.vgaB        (vgaB),
		.vgaHs       (vgaHs),
		.vgaVs       (vgaVs),
		.vgaNewline  (vgaNewline),
		.outOfScreen (outOfScreen)
	);

	always #5 CLK100MHZ = ~CLK100MHZ;

	// one clock, then settle just past the edge
	task automatic stepClock();
		@(posedge CLK100MHZ);
		#1;
	endtask

	task automatic checkValue(input string name, input int actual, input int expected);
		checks++;
		assert (actual == expected) else begin
			$display("Fail at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
			errors++;
		end
	endtask

	// bit 0 red, bit 1 green, bit 2 blue, each spread over four bits
	task automatic checkColour(input rgbPixel colour);
		checkValue("vgaR", int'(vgaR), int'({4{colour[0]}}));
		checkValue("vgaG", int'(vgaG), int'({4{colour[1]}}));
		checkValue("vgaB", int'(vgaB), int'({4{colour[2]}}));
	endtask

	task automatic checkIdleOutputs();
		checkValue("vgaHs", int'(vgaHs), 0);
		checkValue("vgaVs", int'(vgaVs), 0);
		checkValue("vgaNewline", int'(vgaNewline), 0);
		checkValue("outOfScreen", int'(outOfScreen), 0);
		checkColour(3'b000);
	endtask

	task automatic waitPixelEn(input int limit, output bit seen, output int clocks);
		clocks = 0;
		seen = 1'b0;
		while (!seen && clocks < limit) begin
			stepClock();
			clocks++;
			seen = pixelEn;
		end
		assert (seen) else begin
			$display("timeout: no pixelEn pulse within %0d clocks", limit);
			errors++;
		end
	endtask

	task automatic measurePixelGap(input int expected);
		bit seen;
		int clocks;
		waitPixelEn(expected + 10, seen, clocks);
		waitPixelEn(expected + 10, seen, clocks);
		if (seen)
			checkValue("pixelEn spacing", clocks, expected);
	endtask

	task automatic waitHsRise(input int limit, output bit seen, output int clocks);
		logic prev;
		prev = vgaHs;
		clocks = 0;
		seen = 1'b0;
		while (!seen && clocks < limit) begin
			stepClock();
			clocks++;
			seen = vgaHs && !prev;
			prev = vgaHs;
		end
		assert (seen) else begin
			$display("timeout: vgaHs did not rise within %0d clocks", limit);
			errors++;
		end
	endtask

	task automatic waitNewline(input int limit, output bit seen);
		int clocks;
		clocks = 0;
		seen = 1'b0;
		while (!seen && clocks < limit) begin
			stepClock();
			clocks++;
			seen = vgaNewline;
		end
		assert (seen) else begin
			$display("timeout: no vgaNewline pulse within %0d clocks", limit);
			errors++;
		end
	endtask

	task automatic finishTest(input string name);
		$display("%s done, %0d errors", name, errors - testStart);
		testStart = errors;
	endtask

	initial begin
		int  j;
		int  c;
		int  clocks;
		bit  seen;

		reset      = 1'b1;
		delayDebug = 1'b0;
		srcRgb     = 3'b000;
		srcHsync   = 1'b1;
		srcVsync   = 1'b0;
		$readmemh("videoVectors.mem", vectors);
		debugRgb   = vectors[0];
		testStart  = 0;

		// five clocks in reset and the first one after it
		repeat (5) begin
			stepClock();
			checkIdleOutputs();
		end
		reset = 1'b0;
		stepClock();
		checkIdleOutputs();
		finishTest("reset");

		measurePixelGap(`PIXEL_DIV);
		measurePixelGap(`PIXEL_DIV);
		delayDebug = 1'b1;
		measurePixelGap(`SLOW_DIV);
		measurePixelGap(`SLOW_DIV);
		delayDebug = 1'b0;
		finishTest("enable rates");

		// hsync falls on a pixel enable, so counting starts with the next one
		waitPixelEn(20, seen, clocks);
		srcHsync = 1'b0;
		j = 0;
		while (seen && j < `CAPTURE_OFFSET + `LINE_PIXELS - 1) begin
			waitPixelEn(20, seen, clocks);
			j++;
			if (j >= `CAPTURE_OFFSET) begin
				vecIdx = 9'(j - `CAPTURE_OFFSET + 1);
				srcRgb = vectors[vecIdx];
			end
		end
		// last pixel is sampled on this edge
		stepClock();
		srcHsync = 1'b1;
		srcRgb   = 3'b000;
		repeat (4) stepClock();
		waitNewline(FRAME_CLOCKS + LINE_CLOCKS, seen);
		if (seen) begin
			for (c = 1; c <= 4 * `LINE_PIXELS + 1; c++) begin
				stepClock();
				if (c >= 2) begin
					vecIdx = 9'((c - 2) / 4 + 1);
					checkColour(vectors[vecIdx]);
				end
			end
		end
		finishTest("line replay");

		waitHsRise(LINE_CLOCKS + 10, seen, clocks);
		repeat (2) begin
			waitHsRise(LINE_CLOCKS + 10, seen, clocks);
			if (seen)
				checkValue("vgaHs period", clocks, LINE_CLOCKS);
		end
		finishTest("sync period");

		// colours lag outOfScreen by one clock
		borderChecks = 0;
		prevOut = outOfScreen;
		repeat (2 * LINE_CLOCKS) begin
			stepClock();
			if (prevOut && outOfScreen && !vgaHs && !vgaVs) begin
				checkColour(vectors[0]);
				borderChecks++;
			end
			prevOut = outOfScreen;
		end
		assert (borderChecks > 0) else begin
			$display("overlay never checked, no border clocks outside sync");
			errors++;
		end
		finishTest("overlay");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: videoVectors.mem
// first word: debug colour, bit 0 red, bit 1 green, bit 2 blue
// then 400 source pixel colours in line order, one hex digit each, 20 per row
5
3 6 1 7 0 4 2 5 7 1 6 3 0 2 4 7 5 1 3 6
2 0 5 7 4 1 6 3 3 7 0 2 5 6 1 4 7 2 0 5
6 4 1 3 7 5 2 0 4 6 3 1 7 2 5 0 6 3 4 1
0 7 3 5 2 6 4 1 5 0 7 6 2 3 1 4 0 5 7 2
4 1 6 0 3 7 5 2 6 4 1 0 3 5 7 6 2 1 4 3
7 2 0 4 6 1 3 5 0 7 2 4 6 1 5 3 7 0 2 6
1 5 7 2 0 3 6 4 1 2 5 7 4 0 3 6 1 5 2 7
5 3 4 6 1 0 7 2 3 5 6 1 0 4 2 7 3 6 5 0
2 6 5 1 7 4 0 3 6 2 4 5 1 7 0 3 2 4 6 1
6 0 2 3 5 7 1 4 7 3 0 2 5 6 4 1 5 7 0 3
3 4 7 0 2 5 6 1 2 6 7 3 4 1 5 0 4 2 3 7
0 1 3 6 4 2 5 7 5 1 3 0 6 2 7 4 6 1 5 2
7 5 6 2 3 1 0 4 4 0 1 6 7 3 2 5 1 3 7 6
4 3 0 5 6 2 7 1 0 4 5 2 3 7 6 1 3 0 4 5
1 7 2 4 5 0 3 6 7 5 2 1 0 6 3 4 7 6 1 0
5 2 1 7 0 6 4 3 1 3 6 4 2 0 5 7 2 5 0 4
2 4 6 0 1 3 7 5 6 7 4 3 1 5 0 2 0 4 6 3
6 1 5 3 7 4 2 0 3 0 1 7 6 4 2 5 5 2 1 7
3 0 4 1 6 5 1 2 5 6 7 0 4 2 3 1 6 3 2 4
7 6 3 2 4 0 5 1 2 1 3 5 7 0 6 4 1 7 5 6

// File: src.f
+incdir+.
videoPkg.sv
lineSwapIf.sv
clockEnables.sv
lineCapture.sv
lineBuffer.sv
scanTiming.sv
overlayMixer.sv
videoTop.sv
videoTop_tb.sv

// File: Makefile
SOURCES := $(shell grep -v '^+' src.f)

.PHONY: run clean

run: obj_dir/VvideoTop_tb
	./obj_dir/VvideoTop_tb | tee /dev/stderr | grep -x "TEST OK" > /dev/null

obj_dir/VvideoTop_tb: src.f video_macros.svh $(SOURCES)
	verilator --binary --timing --assert --top-module videoTop_tb -f src.f

clean:
	rm -rf obj_dir
